// ==== hdl/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	// lane word width, all lane math wraps at this width
	localparam int DATA_WIDTH = 16;
	localparam int KS_WIDTH = 8;

	typedef logic signed [DATA_WIDTH-1:0] lane_t;

	// mode codes
	localparam logic OP_CONV = 1'b0;
	localparam logic OP_FC = 1'b1;

	// activation codes
	localparam logic [1:0] ACT_NONE = 2'd0;
	localparam logic [1:0] ACT_RELU = 2'd1;

	// window moves of a conv step
	typedef enum logic [1:0] {
		STEP_LOAD = 2'd0,
		STEP_SHIFT = 2'd1,
		STEP_ROW = 2'd2,
		STEP_ROTATE = 2'd3
	} step_kind_t;

	typedef struct packed {
		logic op_type;
		logic [KS_WIDTH-1:0] kernel_size;
		logic [1:0] activation;
	} pass_cfg_t;

	typedef struct packed {
		logic valid;
		step_kind_t kind;
		logic op_type;
		logic [KS_WIDTH-1:0] kernel_size;
	} step_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/pass_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pass_sequencer (
	input wire logic clk,
	input wire logic rst,
	input wire logic op_type,
	input wire logic [conv_pkg::KS_WIDTH-1:0] kernel_size,
	input wire logic [1:0] activation,
	output conv_pkg::step_ctrl_t step,
	output logic capture,
	output conv_pkg::pass_cfg_t cfg
);

	// wide enough for kernel_size squared plus the two trailing cycles
	localparam int CNT_WIDTH = 2 * conv_pkg::KS_WIDTH + 1;

	logic [CNT_WIDTH-1:0] cnt;
	logic [conv_pkg::KS_WIDTH-1:0] row;
	logic [conv_pkg::KS_WIDTH-1:0] col;
	conv_pkg::pass_cfg_t cur_cfg;
	logic [CNT_WIDTH-1:0] ks_ext;
	logic [CNT_WIDTH-1:0] pass_len;

	// counter 0 runs straight from the ports, later counts from the latched copy
	always_comb begin
		if (cnt == '0) begin
			cur_cfg.op_type = op_type;
			cur_cfg.kernel_size = kernel_size;
			cur_cfg.activation = activation;
		end else begin
			cur_cfg = cfg;
		end
	end

	assign ks_ext = CNT_WIDTH'(cur_cfg.kernel_size);

	// N steps: K*K for conv, K for fc
	assign pass_len = (cur_cfg.op_type == conv_pkg::OP_FC) ? ks_ext : ks_ext * ks_ext;

	// last product lands at N, sums are taken one cycle later
	assign capture = (cnt == pass_len + 1'b1);

	always_comb begin
		step.valid = (cnt < pass_len);
		step.op_type = cur_cfg.op_type;
		step.kernel_size = cur_cfg.kernel_size;
		if (cnt == '0) begin
			step.kind = conv_pkg::STEP_LOAD;
		end else if (row == '0) begin
			step.kind = conv_pkg::STEP_SHIFT;
		end else if (col == '0) begin
			step.kind = conv_pkg::STEP_ROW;
		end else begin
			step.kind = conv_pkg::STEP_ROTATE;
		end
	end

	// step counter plus kernel row and column of the current step
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
			row <= '0;
			col <= '0;
		end else if (capture) begin
			cnt <= '0;
			row <= '0;
			col <= '0;
		end else begin
			cnt <= cnt + 1'b1;
			if (step.valid) begin
				if (col == cur_cfg.kernel_size - 1'b1) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// pass configuration, held for the rest of the pass
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg <= '0;
		end else if (cnt == '0) begin
			cfg <= cur_cfg;
		end
	end

	// only 3x3 and 5x5 move patterns exist in the window bank
	conv_ks_legal: assert property (@(posedge clk) disable iff (!rst)
		(cnt == '0 && op_type == conv_pkg::OP_CONV)
		|=> (cfg.kernel_size == 8'd3 || cfg.kernel_size == 8'd5))
		else $error("conv pass latched with kernel_size %0d", cfg.kernel_size);

endmodule

`default_nettype wire

// ==== hdl/window_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module window_shifter #(
	parameter int PARA_X = 3,
	parameter int PARA_Y = 3,
	parameter int KERNEL_MAX = 5
) (
	input wire logic clk,
	input wire logic rst,
	input wire conv_pkg::step_ctrl_t step,
	input wire conv_pkg::lane_t [PARA_X*PARA_Y-1:0] input_data,
	input wire conv_pkg::lane_t weight,
	output conv_pkg::lane_t [PARA_X*PARA_Y-1:0] lanes,
	output conv_pkg::lane_t operand
);

	// a group holds one full kernel row: tile width plus K-1 extra columns
	localparam int GW = PARA_Y + KERNEL_MAX - 1;

	typedef conv_pkg::lane_t [GW-1:0] group_t;

	group_t [PARA_X-1:0] grp;
	group_t [PARA_X-1:0] grp_next;

	// every word moves down one entry, entry 0 wraps to the end of the active row
	function automatic group_t rotate_group(input group_t g, input int len);
		group_t r;
		r = g;
		for (int e = 0; e < GW - 1; e++) begin
			r[e] = g[e + 1];
		end
		r[len - 1] = g[0];
		return r;
	endfunction

	// after K-1 moves column 0 sits just above the tile
	// so a rotate by PARA_Y puts it back at entry 0
	function automatic group_t rewind_group(input group_t g, input int len);
		group_t r;
		int src;
		r = g;
		for (int e = 0; e < GW; e++) begin
			if (e < len) begin
				src = e + PARA_Y;
				if (src >= len) begin
					src = src - len;
				end
				r[e] = g[src];
			end
		end
		return r;
	endfunction

	always_comb begin
		int span;
		span = PARA_Y + int'(step.kernel_size) - 1;
		grp_next = grp;
		if (step.op_type == conv_pkg::OP_FC || step.kind == conv_pkg::STEP_LOAD) begin
			// one input row per group, straight in
			for (int x = 0; x < PARA_X; x++) begin
				for (int y = 0; y < PARA_Y; y++) begin
					grp_next[x][y] = input_data[x*PARA_Y + y];
				end
			end
		end else begin
			case (step.kind)
				conv_pkg::STEP_SHIFT: begin
					// first kernel row, each group pulls its own new column
					for (int x = 0; x < PARA_X; x++) begin
						grp_next[x] = rotate_group(grp[x], span);
						grp_next[x][PARA_Y-1] = input_data[x*PARA_Y];
					end
				end
				conv_pkg::STEP_ROW: begin
					// groups move up one feature row, last group gets a fresh row
					for (int x = 0; x < PARA_X - 1; x++) begin
						grp_next[x] = rewind_group(grp[x+1], span);
					end
					for (int y = 0; y < PARA_Y; y++) begin
						grp_next[PARA_X-1][y] = input_data[y];
					end
				end
				default: begin
					// STEP_ROTATE, upper groups replay their stored row
					for (int x = 0; x < PARA_X - 1; x++) begin
						grp_next[x] = rotate_group(grp[x], span);
					end
					grp_next[PARA_X-1] = rotate_group(grp[PARA_X-1], span);
					grp_next[PARA_X-1][PARA_Y-1] = input_data[0];
				end
			endcase
		end
	end

	// window and broadcast operand move together
	always_ff @(posedge clk) begin
		if (step.valid) begin
			grp <= grp_next;
			operand <= weight;
		end
	end

	// lane (x,y) sees entry y of group x
	always_comb begin
		for (int x = 0; x < PARA_X; x++) begin
			for (int y = 0; y < PARA_Y; y++) begin
				lanes[x*PARA_Y + y] = grp[x][y];
			end
		end
	end

	// the group length is sized for KERNEL_MAX
	ks_fits: assert property (@(posedge clk) disable iff (!rst)
		(step.valid && step.op_type == conv_pkg::OP_CONV) |-> (step.kernel_size <= KERNEL_MAX))
		else $error("kernel_size %0d exceeds KERNEL_MAX", step.kernel_size);

endmodule

`default_nettype wire

// ==== hdl/mac_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_array #(
	parameter int PARA_X = 3,
	parameter int PARA_Y = 3
) (
	input wire logic clk,
	input wire logic rst,
	input wire conv_pkg::lane_t [PARA_X*PARA_Y-1:0] lanes,
	input wire conv_pkg::lane_t operand,
	input wire logic step_valid,
	input wire logic capture,
	output conv_pkg::lane_t [PARA_X*PARA_Y-1:0] sums
);

	localparam int LANES = PARA_X * PARA_Y;

	logic valid_d;
	conv_pkg::lane_t [LANES-1:0] prod;

	// window and operand are registered on the step edge, so add one cycle later
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			valid_d <= 1'b0;
		end else begin
			valid_d <= step_valid;
		end
	end

	// low DATA_WIDTH bits of the product only
	always_comb begin
		for (int k = 0; k < LANES; k++) begin
			prod[k] = lanes[k] * operand;
		end
	end

	// accumulators, cleared as the sums are captured
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sums <= '0;
		end else if (capture) begin
			sums <= '0;
		end else if (valid_d) begin
			for (int k = 0; k < LANES; k++) begin
				sums[k] <= sums[k] + prod[k];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/result_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_stage #(
	parameter int PARA_X = 3,
	parameter int PARA_Y = 3
) (
	input wire logic clk,
	input wire logic rst,
	input wire conv_pkg::lane_t [PARA_X*PARA_Y-1:0] sums,
	input wire logic capture,
	input wire logic [1:0] activation,
	output conv_pkg::lane_t [PARA_X*PARA_Y-1:0] result,
	output logic result_ready
);

	localparam int LANES = PARA_X * PARA_Y;

	conv_pkg::lane_t [LANES-1:0] act;

	always_comb begin
		for (int k = 0; k < LANES; k++) begin
			case (activation)
				conv_pkg::ACT_RELU: begin
					// negative sums clamp to zero
					act[k] = sums[k][conv_pkg::DATA_WIDTH-1] ? '0 : sums[k];
				end
				default: begin
					// none, and any code without a function, passes through
					act[k] = sums[k];
				end
			endcase
		end
	end

	// result holds until the next capture
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result <= '0;
			result_ready <= 1'b0;
		end else begin
			result_ready <= capture;
			if (capture) begin
				result <= act;
			end
		end
	end

	// one capture per pass, so ready is a single-cycle strobe
	ready_pulse: assert property (@(posedge clk) disable iff (!rst)
		result_ready |=> !result_ready)
		else $error("result_ready high for two cycles");

endmodule

`default_nettype wire

// ==== hdl/conv_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_engine #(
	parameter int PARA_X = 3,
	parameter int PARA_Y = 3,
	parameter int KERNEL_MAX = 5
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic op_type,
	input wire logic [1:0] activation,
	input wire logic [conv_pkg::KS_WIDTH-1:0] kernel_size,
	input wire conv_pkg::lane_t [PARA_X*PARA_Y-1:0] input_data,
	input wire conv_pkg::lane_t weight,
	output wire logic result_ready,
	output wire conv_pkg::lane_t [PARA_X*PARA_Y-1:0] result
);

	conv_pkg::step_ctrl_t step;
	conv_pkg::pass_cfg_t cfg;
	logic capture;
	conv_pkg::lane_t [PARA_X*PARA_Y-1:0] lanes;
	conv_pkg::lane_t operand;
	conv_pkg::lane_t [PARA_X*PARA_Y-1:0] sums;

	pass_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.op_type(op_type),
		.kernel_size(kernel_size),
		.activation(activation),
		.step(step),
		.capture(capture),
		.cfg(cfg)
	);

	window_shifter #(
		.PARA_X(PARA_X),
		.PARA_Y(PARA_Y),
		.KERNEL_MAX(KERNEL_MAX)
	) u_shifter (
		.clk(clk),
		.rst(rst),
		.step(step),
		.input_data(input_data),
		.weight(weight),
		.lanes(lanes),
		.operand(operand)
	);

	// step valid is delayed inside to line up with the registered window
	mac_array #(
		.PARA_X(PARA_X),
		.PARA_Y(PARA_Y)
	) u_mac (
		.clk(clk),
		.rst(rst),
		.lanes(lanes),
		.operand(operand),
		.step_valid(step.valid),
		.capture(capture),
		.sums(sums)
	);

	result_stage #(
		.PARA_X(PARA_X),
		.PARA_Y(PARA_Y)
	) u_result (
		.clk(clk),
		.rst(rst),
		.sums(sums),
		.capture(capture),
		.activation(cfg.activation),
		.result(result),
		.result_ready(result_ready)
	);

endmodule

`default_nettype wire

// ==== sim/conv_model.svh ====
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// keep the low DATA_WIDTH bits, as the lanes do
function automatic conv_pkg::lane_t to_lane(input int v);
	return conv_pkg::lane_t'(v);
endfunction

// relu zeroes any word with the sign bit set
function automatic conv_pkg::lane_t activate(input conv_pkg::lane_t v, input logic [1:0] act);
	if (act == conv_pkg::ACT_RELU && v < 0) begin
		return '0;
	end
	return v;
endfunction

// input_data and weight per step, in kernel row then column order
function automatic void build_conv_steps(input int k);
	int i;
	int j;
	for (int c = 0; c < k * k; c++) begin
		i = c / k;
		j = c % k;
		stim_data[c] = '0;
		stim_weight[c] = to_lane(ker[i][j]);
		if (c == 0) begin
			for (int x = 0; x < PARA_X; x++) begin
				for (int y = 0; y < PARA_Y; y++) begin
					stim_data[c][x*PARA_Y + y] = to_lane(fm[x][y]);
				end
			end
		end else if (i == 0) begin
			// one new column per group
			for (int x = 0; x < PARA_X; x++) begin
				stim_data[c][x*PARA_Y] = to_lane(fm[x][PARA_Y-1+j]);
			end
		end else if (j == 0) begin
			// fresh feature row for the last group
			for (int y = 0; y < PARA_Y; y++) begin
				stim_data[c][y] = to_lane(fm[PARA_X-1+i][y]);
			end
		end else begin
			stim_data[c][0] = to_lane(fm[PARA_X-1+i][PARA_Y-1+j]);
		end
	end
endfunction

// direct weighted sum over the K by K window of each output pixel
function automatic void conv_expected(input int k, input logic [1:0] act);
	int acc;
	for (int x = 0; x < PARA_X; x++) begin
		for (int y = 0; y < PARA_Y; y++) begin
			acc = 0;
			for (int i = 0; i < k; i++) begin
				for (int j = 0; j < k; j++) begin
					acc = acc + fm[x+i][y+j] * ker[i][j];
				end
			end
			exp_tile[x*PARA_Y + y] = activate(to_lane(acc), act);
		end
	end
endfunction

// each lane's weight stream against the broadcast features
function automatic void fc_expected(input int k, input logic [1:0] act);
	int acc;
	for (int l = 0; l < LANES; l++) begin
		acc = 0;
		for (int c = 0; c < k; c++) begin
			acc = acc + int'(stim_data[c][l]) * int'(stim_weight[c]);
		end
		exp_tile[l] = activate(to_lane(acc), act);
	end
endfunction

`endif

// ==== sim/tb_conv_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_conv_engine;

	localparam int PARA_X = 3;
	localparam int PARA_Y = 3;
	localparam int KERNEL_MAX = 5;
	localparam int LANES = PARA_X * PARA_Y;
	localparam int FM_ROWS = PARA_X + KERNEL_MAX - 1;
	localparam int FM_COLS = PARA_Y + KERNEL_MAX - 1;
	localparam int MAX_STEPS = KERNEL_MAX * KERNEL_MAX;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 7;

	typedef struct packed {
		logic op_type;
		logic [conv_pkg::KS_WIDTH-1:0] kernel_size;
		logic [1:0] activation;
		// 0 draws 0..15, 1 draws mixed sign values wide enough to wrap
		logic mixed;
		logic force_neg;
	} test_entry_t;

	localparam test_entry_t TESTS [NUM_TESTS] = '{
		'{conv_pkg::OP_CONV, 8'd3, conv_pkg::ACT_NONE, 1'b0, 1'b0},
		'{conv_pkg::OP_CONV, 8'd5, conv_pkg::ACT_NONE, 1'b1, 1'b0},
		'{conv_pkg::OP_CONV, 8'd3, conv_pkg::ACT_RELU, 1'b1, 1'b1},
		'{conv_pkg::OP_CONV, 8'd5, conv_pkg::ACT_RELU, 1'b1, 1'b0},
		'{conv_pkg::OP_FC, 8'd7, conv_pkg::ACT_NONE, 1'b1, 1'b0},
		'{conv_pkg::OP_FC, 8'd7, conv_pkg::ACT_RELU, 1'b0, 1'b1},
		'{conv_pkg::OP_CONV, 8'd3, conv_pkg::ACT_NONE, 1'b1, 1'b0}
	};

	string test_names [NUM_TESTS] = '{"conv3_small", "conv5_mixed", "conv3_relu_neg",
		"conv5_relu_mixed", "fc7_mixed", "fc7_relu_neg", "conv3_after_fc"};

	logic clk = 1'b0;
	logic rst;
	logic op_type;
	logic [1:0] activation;
	logic [conv_pkg::KS_WIDTH-1:0] kernel_size;
	conv_pkg::lane_t [LANES-1:0] input_data;
	conv_pkg::lane_t weight;
	logic result_ready;
	conv_pkg::lane_t [LANES-1:0] result;

	int fm [FM_ROWS][FM_COLS];
	int ker [KERNEL_MAX][KERNEL_MAX];
	conv_pkg::lane_t [LANES-1:0] stim_data [MAX_STEPS];
	conv_pkg::lane_t stim_weight [MAX_STEPS];
	conv_pkg::lane_t [LANES-1:0] exp_tile;
	conv_pkg::lane_t [LANES-1:0] prev_exp;
	bit test_failed [NUM_TESTS];

	`include "conv_model.svh"

	conv_engine #(
		.PARA_X(PARA_X),
		.PARA_Y(PARA_Y),
		.KERNEL_MAX(KERNEL_MAX)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.op_type(op_type),
		.activation(activation),
		.kernel_size(kernel_size),
		.input_data(input_data),
		.weight(weight),
		.result_ready(result_ready),
		.result(result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int pass_steps(input test_entry_t t);
		int k;
		k = int'(t.kernel_size);
		return (t.op_type == conv_pkg::OP_FC) ? k : k * k;
	endfunction

	// force_neg uses small magnitudes with the sign picked by the caller
	function automatic int draw(input test_entry_t t, input bit neg);
		int v;
		if (t.force_neg) begin
			v = int'($urandom_range(15, 1));
			return neg ? -v : v;
		end
		if (t.mixed) begin
			return int'($urandom_range(4095, 0)) - 2048;
		end
		return int'($urandom_range(15, 0));
	endfunction

	function automatic void make_data(input test_entry_t t);
		int k;
		int cols;
		k = int'(t.kernel_size);
		cols = PARA_Y + k - 1;
		if (t.op_type == conv_pkg::OP_FC) begin
			for (int c = 0; c < k; c++) begin
				stim_weight[c] = to_lane(draw(t, 1'b0));
				// odd lanes carry negative weights under force_neg
				for (int l = 0; l < LANES; l++) begin
					stim_data[c][l] = to_lane(draw(t, l % 2 == 1));
				end
			end
		end else begin
			// left half of the map negative, so left lanes sum below zero
			for (int r = 0; r < PARA_X + k - 1; r++) begin
				for (int c = 0; c < cols; c++) begin
					fm[r][c] = draw(t, c < cols / 2);
				end
			end
			for (int i = 0; i < k; i++) begin
				for (int j = 0; j < k; j++) begin
					ker[i][j] = draw(t, 1'b0);
				end
			end
		end
	endfunction

	// configuration is only sampled at counter 0
	task automatic drive_step(input test_entry_t t, input int c, input int n);
		rst <= 1'b1;
		if (c == 0) begin
			op_type <= t.op_type;
			kernel_size <= t.kernel_size;
			activation <= t.activation;
		end
		if (c < n) begin
			input_data <= stim_data[c];
			weight <= stim_weight[c];
		end else begin
			input_data <= '0;
			weight <= '0;
		end
	endtask

	// previous pass result, due at its counter N+2
	task automatic check_result(input int ti);
		if (result_ready !== 1'b1) begin
			$display("%s: result_ready did not pulse at the end of the pass", test_names[ti]);
			test_failed[ti] = 1'b1;
		end else begin
			for (int k = 0; k < LANES; k++) begin
				if (result[k] !== prev_exp[k]) begin
					$display("mismatch %s lane %0d expected %0d actual %0d",
						test_names[ti], k, prev_exp[k], result[k]);
					test_failed[ti] = 1'b1;
				end
			end
		end
		$display("%s: %s", test_names[ti], test_failed[ti] ? "failed" : "ok");
	endtask

	initial begin
		test_entry_t t;
		int n;
		int failed;
		void'($urandom(28));
		rst = 1'b0;
		op_type = conv_pkg::OP_CONV;
		kernel_size = 8'd3;
		activation = conv_pkg::ACT_NONE;
		input_data = '0;
		weight = '0;
		// released together with step 0 on the last reset edge
		repeat (RESET_CYCLES - 1) @(posedge clk);
		for (int ti = 0; ti < NUM_TESTS; ti++) begin
			t = TESTS[ti];
			n = pass_steps(t);
			make_data(t);
			if (t.op_type == conv_pkg::OP_FC) begin
				fc_expected(int'(t.kernel_size), t.activation);
			end else begin
				build_conv_steps(int'(t.kernel_size));
				conv_expected(int'(t.kernel_size), t.activation);
			end
			for (int c = 0; c < n + 2; c++) begin
				@(posedge clk);
				drive_step(t, c, n);
				@(negedge clk);
				if (c == 0 && ti > 0) begin
					check_result(ti - 1);
				end else if (result_ready !== 1'b0) begin
					$display("%s: result_ready high at counter %0d", test_names[ti], c);
					test_failed[ti] = 1'b1;
				end
				if (ti == 0 && c == 0 && result !== '0) begin
					$display("%s: result not cleared by reset", test_names[ti]);
					test_failed[ti] = 1'b1;
				end
			end
			prev_exp = exp_tile;
		end
		// idle conv pass to collect the last result
		@(posedge clk);
		op_type <= conv_pkg::OP_CONV;
		kernel_size <= 8'd3;
		activation <= conv_pkg::ACT_NONE;
		input_data <= '0;
		weight <= '0;
		@(negedge clk);
		check_result(NUM_TESTS - 1);
		failed = 0;
		for (int ti = 0; ti < NUM_TESTS; ti++) begin
			failed += int'(test_failed[ti]);
		end
		$display("tests %0d, passed %0d, failed %0d", NUM_TESTS, NUM_TESTS - failed, failed);
		if (failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		int cycles;
		cycles = RESET_CYCLES + 1;
		for (int ti = 0; ti < NUM_TESTS; ti++) begin
			cycles += pass_steps(TESTS[ti]) + 2;
		end
		// margin of more than one long pass
		cycles += 40;
		#(cycles * CLK_PERIOD);
		$display("timeout: run still going after %0d cycles", cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+sim
hdl/conv_pkg.sv
hdl/pass_sequencer.sv
hdl/window_shifter.sv
hdl/mac_array.sv
hdl/result_stage.sv
hdl/conv_engine.sv
sim/tb_conv_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP := tb_conv_engine
FILELIST := sim.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) sim/conv_model.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
